// File: design/aether_pkg.sv
package aether_pkg;

  // -------------------------------------------------------------------------
  // Widths and sizes
  // -------------------------------------------------------------------------
  localparam int DATA_W       = 16;
  localparam int WGT_W        = 8;
  localparam int KERNEL_TAPS  = 9;  // 3x3 kernel
  localparam int ENGINE_COUNT = 4;
  localparam int WGT_DEPTH    = ENGINE_COUNT * KERNEL_TAPS;
  localparam int MEM_AW       = 8;
  localparam int BUF_DEPTH    = 64;

  typedef logic [DATA_W-1:0]              word_t;
  typedef logic [WGT_W-1:0]               weight_t;   // Signed weight
  typedef logic [$clog2(WGT_DEPTH)-1:0]   wgt_idx_t;  // Engine * 9 + tap
  typedef logic [MEM_AW-1:0]              mem_addr_t;
  typedef logic [$clog2(BUF_DEPTH)-1:0]   buf_addr_t;

  // -------------------------------------------------------------------------
  // Register map
  // -------------------------------------------------------------------------
  typedef enum logic [3:0] {
    VERSN = 4'd0,
    HWRID = 4'd1,
    MSTRT = 4'd2,
    MENDD = 4'd3,
    BCFG1 = 4'd4,
    STATS = 4'd5
  } reg_sel_e;

  localparam word_t VERSN_VALUE = 16'h6C00;
  localparam word_t HWRID_VALUE = 16'hB2E9;
  localparam word_t BCFG1_MAX   = word_t'(ENGINE_COUNT);  // Reset value and write clamp

  // Host instructions
  typedef enum logic [3:0] {
    NOP      = 4'd0,
    RD_REG   = 4'd1,
    WR_REG   = 4'd2,
    LDW_STRT = 4'd3,
    LDW_CONT = 4'd4,
    LDW_MOVE = 4'd5,
    LDW_CWGT = 4'd6,
    RD_WGT   = 4'd7
  } opcode_e;

  // -------------------------------------------------------------------------
  // Wishbone classic bus
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    mem_addr_t adr;
    word_t     dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  // Shared by the mover and the loader
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    NEXT
  } xfer_state_e;

endpackage

// File: design/aether_decoder.sv
`timescale 1ns/100ps

module aether_decoder (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  aether_pkg::opcode_e   instruction_i,
  input  aether_pkg::reg_sel_e  param_1_i,
  input  aether_pkg::word_t     param_2_i,
  input  logic                  mover_busy_i,
  input  logic                  loader_busy_i,
  input  aether_pkg::weight_t   weight_i,
  output aether_pkg::word_t     data_o,
  output logic                  interrupt_o,
  output logic                  buf_we_o,
  output aether_pkg::buf_addr_t buf_waddr_o,
  output aether_pkg::word_t     buf_wdata_o,
  output aether_pkg::mem_addr_t mem_start_o,
  output aether_pkg::mem_addr_t mem_end_o,
  output aether_pkg::word_t     engine_count_o,
  output logic                  move_start_o,
  output logic                  load_start_o,
  output aether_pkg::wgt_idx_t  weight_idx_o
);

  typedef struct packed {
    aether_pkg::opcode_e  op;
    aether_pkg::reg_sel_e sel;
    aether_pkg::word_t    arg;
  } cmd_t;

  cmd_t                  cmd_q;    // Sampled host command
  aether_pkg::word_t     mstrt_q;
  aether_pkg::word_t     mendd_q;
  aether_pkg::word_t     bcfg1_q;
  aether_pkg::word_t     stats;
  aether_pkg::word_t     reg_rdata;
  aether_pkg::buf_addr_t wptr_q;   // Buffer write pointer

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      cmd_q <= '{op: aether_pkg::NOP, sel: aether_pkg::VERSN, arg: '0};
    else
      cmd_q <= '{op: instruction_i, sel: param_1_i, arg: param_2_i};
  end

  // -------------------------------------------------------------------------
  // Register file and buffer pointer
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mstrt_q <= '0;
      mendd_q <= '0;
      bcfg1_q <= aether_pkg::BCFG1_MAX;
    end
    else if (cmd_q.op == aether_pkg::WR_REG)
    begin
      case (cmd_q.sel)
        aether_pkg::MSTRT: mstrt_q <= cmd_q.arg;
        aether_pkg::MENDD: mendd_q <= cmd_q.arg;
        aether_pkg::BCFG1:
          bcfg1_q <= (cmd_q.arg > aether_pkg::BCFG1_MAX) ? aether_pkg::BCFG1_MAX : cmd_q.arg;
        default: ;  // Read-only or unmapped
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      wptr_q <= '0;
    else if (cmd_q.op == aether_pkg::LDW_STRT)
      wptr_q <= '0;
    else if (cmd_q.op == aether_pkg::LDW_CONT)
      wptr_q <= wptr_q + 1'b1;  // Wraps at buffer depth
  end

  assign stats = aether_pkg::word_t'({loader_busy_i, mover_busy_i});

  always_comb
  begin
    case (cmd_q.sel)
      aether_pkg::VERSN: reg_rdata = aether_pkg::VERSN_VALUE;
      aether_pkg::HWRID: reg_rdata = aether_pkg::HWRID_VALUE;
      aether_pkg::MSTRT: reg_rdata = mstrt_q;
      aether_pkg::MENDD: reg_rdata = mendd_q;
      aether_pkg::BCFG1: reg_rdata = bcfg1_q;
      aether_pkg::STATS: reg_rdata = stats;
      default:           reg_rdata = '0;
    endcase
  end

  // Readback register, holds until the next read
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      data_o <= '0;
    else if (cmd_q.op == aether_pkg::RD_REG)
      data_o <= reg_rdata;
    else if (cmd_q.op == aether_pkg::RD_WGT)
      data_o <= {{(aether_pkg::DATA_W - aether_pkg::WGT_W){weight_i[aether_pkg::WGT_W-1]}},
                 weight_i};
  end

  assign move_start_o   = (cmd_q.op == aether_pkg::LDW_MOVE) && !mover_busy_i;
  assign load_start_o   = (cmd_q.op == aether_pkg::LDW_CWGT) && !loader_busy_i;
  assign interrupt_o    = mover_busy_i || loader_busy_i;
  assign buf_we_o       = (cmd_q.op == aether_pkg::LDW_CONT);
  assign buf_waddr_o    = wptr_q;
  assign buf_wdata_o    = cmd_q.arg;
  assign mem_start_o    = mstrt_q[aether_pkg::MEM_AW-1:0];
  assign mem_end_o      = mendd_q[aether_pkg::MEM_AW-1:0];
  assign engine_count_o = bcfg1_q;
  assign weight_idx_o   = cmd_q.arg[$bits(aether_pkg::wgt_idx_t)-1:0];

  // Each start pulse makes its unit busy from the next cycle
  a_move_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    move_start_o |=> mover_busy_i);
  a_load_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    load_start_o |=> loader_busy_i);

endmodule

// File: design/aether_input_buffer.sv
`timescale 1ns/100ps

module aether_input_buffer (
  input  logic                  clk_i,
  input  logic                  we_i,
  input  aether_pkg::buf_addr_t waddr_i,
  input  aether_pkg::word_t     wdata_i,
  input  aether_pkg::buf_addr_t raddr_i,
  output aether_pkg::word_t     rdata_o
);

  aether_pkg::word_t mem_q [aether_pkg::BUF_DEPTH];

  // Host side
  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem_q[waddr_i] <= wdata_i;
  end

  // Mover side, one cycle read latency
  always_ff @(posedge clk_i)
  begin
    rdata_o <= mem_q[raddr_i];
  end

endmodule

// File: design/aether_buffer_mover.sv
`timescale 1ns/100ps

module aether_buffer_mover (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  start_i,
  input  aether_pkg::mem_addr_t mem_start_i,
  input  aether_pkg::mem_addr_t mem_end_i,
  output aether_pkg::buf_addr_t buf_raddr_o,
  input  aether_pkg::word_t     buf_rdata_i,
  output aether_pkg::wb_req_t   wb_o,
  input  aether_pkg::wb_rsp_t   wb_i,
  output logic                  busy_o
);

  aether_pkg::xfer_state_e state_q;
  aether_pkg::mem_addr_t   base_q;
  aether_pkg::mem_addr_t   last_q;  // Offset of the final word
  aether_pkg::mem_addr_t   k_q;     // Current word offset

  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      base_q <= mem_start_i;
      last_q <= mem_end_i - mem_start_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= aether_pkg::IDLE;
      k_q     <= '0;
    end
    else
    begin
      case (state_q)
        aether_pkg::IDLE:
        begin
          if (start_i)
          begin
            k_q     <= '0;
            state_q <= aether_pkg::NEXT;
          end
        end
        aether_pkg::NEXT: state_q <= aether_pkg::REQ;  // Buffer word fetched here
        aether_pkg::REQ:
        begin
          if (wb_i.ack)
          begin
            if (k_q == last_q)
              state_q <= aether_pkg::IDLE;
            else
            begin
              k_q     <= k_q + 1'b1;
              state_q <= aether_pkg::NEXT;
            end
          end
        end
        default: state_q <= aether_pkg::IDLE;
      endcase
    end
  end

  assign buf_raddr_o = k_q[$bits(aether_pkg::buf_addr_t)-1:0];

  always_comb
  begin
    wb_o     = '0;
    wb_o.cyc = (state_q == aether_pkg::REQ);
    wb_o.stb = (state_q == aether_pkg::REQ);
    wb_o.we  = 1'b1;  // Write-only master
    wb_o.adr = base_q + k_q;
    wb_o.dat = buf_rdata_i;  // Stable while k_q holds
  end

  assign busy_o = (state_q != aether_pkg::IDLE);

endmodule

// File: design/aether_weight_loader.sv
`timescale 1ns/100ps

module aether_weight_loader (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  start_i,
  input  aether_pkg::mem_addr_t mem_start_i,
  input  aether_pkg::word_t     engine_count_i,
  output aether_pkg::wb_req_t   wb_o,
  input  aether_pkg::wb_rsp_t   wb_i,
  output logic                  busy_o,
  input  aether_pkg::wgt_idx_t  weight_idx_i,
  output aether_pkg::weight_t   weight_o
);

  aether_pkg::xfer_state_e state_q;
  aether_pkg::mem_addr_t   addr_q;
  aether_pkg::wgt_idx_t    total_q;   // BCFG1 * 9 entries to fill
  aether_pkg::wgt_idx_t    wr_idx_q;  // Next entry for the low byte
  aether_pkg::weight_t     store_q [aether_pkg::WGT_DEPTH];
  logic                    we_lo;
  logic                    we_hi;

  assign we_lo = (state_q == aether_pkg::REQ) && wb_i.ack;
  assign we_hi = we_lo && (wr_idx_q + 1'b1 < total_q);  // Odd count drops the last high byte

  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      addr_q  <= mem_start_i;
      total_q <= aether_pkg::wgt_idx_t'(engine_count_i * aether_pkg::KERNEL_TAPS);
    end
    else if (we_lo)
      addr_q <= addr_q + 1'b1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q  <= aether_pkg::IDLE;
      wr_idx_q <= '0;
    end
    else
    begin
      case (state_q)
        aether_pkg::IDLE:
        begin
          if (start_i)
          begin
            wr_idx_q <= '0;
            state_q  <= aether_pkg::NEXT;
          end
        end
        aether_pkg::NEXT:
        begin
          if (wr_idx_q < total_q)
            state_q <= aether_pkg::REQ;
          else
            state_q <= aether_pkg::IDLE;
        end
        aether_pkg::REQ:
        begin
          if (wb_i.ack)
          begin
            wr_idx_q <= wr_idx_q + 2'd2;  // Two weights per word
            state_q  <= aether_pkg::NEXT;
          end
        end
        default: state_q <= aether_pkg::IDLE;
      endcase
    end
  end

  // Kernel weight store, low byte first
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < aether_pkg::WGT_DEPTH; i++)
        store_q[i] <= '0;
    end
    else
    begin
      if (we_lo)
        store_q[wr_idx_q] <= wb_i.dat[aether_pkg::WGT_W-1:0];
      if (we_hi)
        store_q[wr_idx_q + 1'b1] <= wb_i.dat[aether_pkg::DATA_W-1:aether_pkg::WGT_W];
    end
  end

  assign weight_o = (weight_idx_i < aether_pkg::WGT_DEPTH) ? store_q[weight_idx_i] : '0;

  always_comb
  begin
    wb_o     = '0;
    wb_o.cyc = (state_q == aether_pkg::REQ);
    wb_o.stb = (state_q == aether_pkg::REQ);
    wb_o.adr = addr_q;  // Read-only master
  end

  assign busy_o = (state_q != aether_pkg::IDLE);

  // Store writes stay inside the count taken at start
  a_store_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    we_lo |-> (wr_idx_q < total_q) && $stable(total_q));

endmodule

// File: design/aether_mem_arbiter.sv
`timescale 1ns/100ps

module aether_mem_arbiter (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  aether_pkg::wb_req_t m0_req_i,
  output aether_pkg::wb_rsp_t m0_rsp_o,
  input  aether_pkg::wb_req_t m1_req_i,
  output aether_pkg::wb_rsp_t m1_rsp_o,
  output aether_pkg::wb_req_t s_req_o,
  input  aether_pkg::wb_rsp_t s_rsp_i
);

  logic                locked_q;  // Bus owned
  logic                gnt_q;     // Owner, or last owner while free
  aether_pkg::wb_req_t owner_req;

  assign owner_req = gnt_q ? m1_req_i : m0_req_i;

  // -------------------------------------------------------------------------
  // Grant, locked until the owner drops cyc
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      locked_q <= 1'b0;
      gnt_q    <= 1'b1;  // Port 0 wins the first tie
    end
    else if (locked_q)
    begin
      if (!owner_req.cyc)
        locked_q <= 1'b0;
    end
    else if (m0_req_i.cyc || m1_req_i.cyc)
    begin
      locked_q <= 1'b1;
      if (m0_req_i.cyc && m1_req_i.cyc)
        gnt_q <= !gnt_q;  // Round robin
      else
        gnt_q <= m1_req_i.cyc;
    end
  end

  assign s_req_o  = locked_q ? owner_req : '0;
  assign m0_rsp_o = (locked_q && !gnt_q) ? s_rsp_i : '0;
  assign m1_rsp_o = (locked_q && gnt_q) ? s_rsp_i : '0;

  // Slave ack lands on the same grant that issued the request
  a_ack_owner: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_rsp_i.ack |-> locked_q && $past(locked_q) && $stable(gnt_q));

endmodule

// File: design/aether_sys_ram.sv
`timescale 1ns/100ps

module aether_sys_ram (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  aether_pkg::wb_req_t wb_i,
  output aether_pkg::wb_rsp_t wb_o
);

  aether_pkg::word_t mem_q [2**aether_pkg::MEM_AW];
  aether_pkg::word_t rdata_q;
  logic              ack_q;
  logic              req;

  assign req = wb_i.cyc && wb_i.stb;

  // Single-cycle ack per request
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= req && !ack_q;
  end

  always_ff @(posedge clk_i)
  begin
    if (req && wb_i.we)
      mem_q[wb_i.adr] <= wb_i.dat;
    rdata_q <= mem_q[wb_i.adr];  // Valid with ack
  end

  assign wb_o = '{ack: ack_q, dat: rdata_q};

  a_ack_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_q |-> req);

endmodule

// File: design/aether_engine.sv
`timescale 1ns/100ps

module aether_engine (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  aether_pkg::opcode_e  instruction_i,
  input  aether_pkg::reg_sel_e param_1_i,
  input  aether_pkg::word_t    param_2_i,
  output aether_pkg::word_t    data_o,
  output logic                 interrupt_o
);

  logic                  mover_busy;
  logic                  loader_busy;
  logic                  move_start;
  logic                  load_start;
  logic                  buf_we;
  aether_pkg::buf_addr_t buf_waddr;
  aether_pkg::word_t     buf_wdata;
  aether_pkg::buf_addr_t buf_raddr;
  aether_pkg::word_t     buf_rdata;
  aether_pkg::mem_addr_t mem_start;
  aether_pkg::mem_addr_t mem_end;
  aether_pkg::word_t     engine_count;
  aether_pkg::wgt_idx_t  weight_idx;
  aether_pkg::weight_t   weight;
  aether_pkg::wb_req_t   mover_req;
  aether_pkg::wb_rsp_t   mover_rsp;
  aether_pkg::wb_req_t   loader_req;
  aether_pkg::wb_rsp_t   loader_rsp;
  aether_pkg::wb_req_t   ram_req;
  aether_pkg::wb_rsp_t   ram_rsp;

  // -------------------------------------------------------------------------
  // Host side
  // -------------------------------------------------------------------------
  aether_decoder u_decoder (
    .clk_i, .arst_n_i, .instruction_i, .param_1_i, .param_2_i,
    .mover_busy_i(mover_busy), .loader_busy_i(loader_busy), .weight_i(weight),
    .data_o, .interrupt_o,
    .buf_we_o(buf_we), .buf_waddr_o(buf_waddr), .buf_wdata_o(buf_wdata),
    .mem_start_o(mem_start), .mem_end_o(mem_end), .engine_count_o(engine_count),
    .move_start_o(move_start), .load_start_o(load_start), .weight_idx_o(weight_idx)
  );

  aether_input_buffer u_input_buffer (
    .clk_i, .we_i(buf_we), .waddr_i(buf_waddr), .wdata_i(buf_wdata),
    .raddr_i(buf_raddr), .rdata_o(buf_rdata)
  );

  // -------------------------------------------------------------------------
  // Memory masters, arbiter and system RAM
  // -------------------------------------------------------------------------
  aether_buffer_mover u_buffer_mover (
    .clk_i, .arst_n_i, .start_i(move_start),
    .mem_start_i(mem_start), .mem_end_i(mem_end),
    .buf_raddr_o(buf_raddr), .buf_rdata_i(buf_rdata),
    .wb_o(mover_req), .wb_i(mover_rsp), .busy_o(mover_busy)
  );

  aether_weight_loader u_weight_loader (
    .clk_i, .arst_n_i, .start_i(load_start),
    .mem_start_i(mem_start), .engine_count_i(engine_count),
    .wb_o(loader_req), .wb_i(loader_rsp), .busy_o(loader_busy),
    .weight_idx_i(weight_idx), .weight_o(weight)
  );

  aether_mem_arbiter u_mem_arbiter (
    .clk_i, .arst_n_i,
    .m0_req_i(mover_req), .m0_rsp_o(mover_rsp),    // Mover on port 0
    .m1_req_i(loader_req), .m1_rsp_o(loader_rsp),
    .s_req_o(ram_req), .s_rsp_i(ram_rsp)
  );

  aether_sys_ram u_sys_ram (
    .clk_i, .arst_n_i, .wb_i(ram_req), .wb_o(ram_rsp)
  );

endmodule

// File: verif/aether_clk_gen.sv
`timescale 1ns/100ps

module aether_clk_gen (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

endmodule

// File: verif/aether_engine_tb.sv
`timescale 1ns/100ps

module aether_engine_tb;

  logic                 clk_i;
  logic                 arst_n_i;
  aether_pkg::opcode_e  instruction_i;
  aether_pkg::reg_sel_e param_1_i;
  aether_pkg::word_t    param_2_i;
  aether_pkg::word_t    data_o;
  logic                 interrupt_o;

  // Step table, one entry per host command
  string                step_name [$];
  aether_pkg::opcode_e  step_op [$];
  aether_pkg::reg_sel_e step_sel [$];
  aether_pkg::word_t    step_arg [$];
  bit                   step_exp [$];
  aether_pkg::word_t    step_val [$];

  aether_pkg::word_t    buf_words [aether_pkg::WGT_DEPTH / 2];  // Host words, two weights each
  aether_pkg::word_t    wgt_model [aether_pkg::WGT_DEPTH];      // Expected RD_WGT results
  integer               seed;
  int                   errors;
  int                   timeouts;

  aether_clk_gen u_clk_gen (
    .clk_o(clk_i)
  );

  aether_engine dut0 (
    .clk_i,
    .arst_n_i,
    .instruction_i,
    .param_1_i,
    .param_2_i,
    .data_o,
    .interrupt_o
  );

  // --------------------------------------------------------------------------
  // Host command helpers
  // --------------------------------------------------------------------------
  task automatic drive_cmd(input aether_pkg::opcode_e op, input aether_pkg::reg_sel_e sel,
                           input aether_pkg::word_t arg);
    instruction_i = op;
    param_1_i     = sel;
    param_2_i     = arg;
  endtask

  task automatic drive_idle();
    drive_cmd(aether_pkg::NOP, aether_pkg::VERSN, '0);
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    arst_n_i = 1'b0;
    drive_idle();
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;
  endtask

  task automatic check_word(input string name, input aether_pkg::word_t exp,
                            input aether_pkg::word_t act);
    if (act !== exp)
    begin
      $display("Mismatch in %s: expected 0x%04h, actual 0x%04h", name, exp, act);
      errors++;
    end
  endtask

  // Result lands two rising edges after the command
  task automatic read_register(input aether_pkg::reg_sel_e sel,
                               output aether_pkg::word_t value);
    @(negedge clk_i);
    drive_cmd(aether_pkg::RD_REG, sel, '0);
    @(negedge clk_i);
    drive_idle();
    @(negedge clk_i);
    value = data_o;
  endtask

  // Busy window of a move or load, then completion
  task automatic await_transfer(input string name, input aether_pkg::word_t busy_stats);
    int                cycles;
    aether_pkg::word_t stats;
    cycles = 0;
    while (!interrupt_o && cycles < 16)
    begin
      @(negedge clk_i);
      drive_idle();
      cycles++;
    end
    if (!interrupt_o)
    begin
      $display("Timeout: interrupt_o never went high after %s", name);
      timeouts++;
    end
    else
    begin
      read_register(aether_pkg::STATS, stats);
      check_word({name, "_stats_busy"}, busy_stats, stats);
      check_word({name, "_irq_busy"}, 16'h0001, {15'b0, interrupt_o});
      cycles = 0;
      while (interrupt_o && cycles < 500)
      begin
        @(negedge clk_i);
        drive_idle();
        cycles++;
      end
      if (interrupt_o)
      begin
        $display("Timeout: interrupt_o still high 500 cycles into %s", name);
        timeouts++;
      end
      else
      begin
        read_register(aether_pkg::STATS, stats);
        check_word({name, "_stats_done"}, 16'h0000, stats);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Step table
  // --------------------------------------------------------------------------
  task automatic add_step(input string name, input aether_pkg::opcode_e op,
                          input aether_pkg::reg_sel_e sel, input aether_pkg::word_t arg,
                          input bit exp, input aether_pkg::word_t val);
    step_name.push_back(name);
    step_op.push_back(op);
    step_sel.push_back(sel);
    step_arg.push_back(arg);
    step_exp.push_back(exp);
    step_val.push_back(val);
  endtask

  task automatic clear_steps();
    step_name.delete();
    step_op.delete();
    step_sel.delete();
    step_arg.delete();
    step_exp.delete();
    step_val.delete();
  endtask

  task automatic run_steps();
    for (int i = 0; i < step_op.size(); i++)
    begin
      @(negedge clk_i);
      drive_cmd(step_op[i], step_sel[i], step_arg[i]);
      if (step_exp[i])
      begin
        @(negedge clk_i);
        drive_idle();
        @(negedge clk_i);
        check_word(step_name[i], step_val[i], data_o);
      end
      else if (step_op[i] == aether_pkg::LDW_MOVE)
        await_transfer(step_name[i], 16'h0001);  // Mover busy bit
      else if (step_op[i] == aether_pkg::LDW_CWGT)
        await_transfer(step_name[i], 16'h0002);  // Loader busy bit
    end
    @(negedge clk_i);
    drive_idle();
  endtask

  task automatic add_weight_reads(input int valid_count);
    for (int idx = 0; idx < aether_pkg::WGT_DEPTH; idx++)
      add_step($sformatf("rd_wgt_%0d", idx), aether_pkg::RD_WGT, aether_pkg::VERSN,
               aether_pkg::word_t'(idx), 1'b1, (idx < valid_count) ? wgt_model[idx] : '0);
  endtask

  task automatic build_main_steps();
    clear_steps();
    add_step("versn_reset", aether_pkg::RD_REG, aether_pkg::VERSN, '0, 1'b1, 16'h6C00);
    add_step("hwrid_reset", aether_pkg::RD_REG, aether_pkg::HWRID, '0, 1'b1, 16'hB2E9);
    add_step("bcfg1_reset", aether_pkg::RD_REG, aether_pkg::BCFG1, '0, 1'b1, 16'h0004);
    add_step("stats_reset", aether_pkg::RD_REG, aether_pkg::STATS, '0, 1'b1, 16'h0000);
    // Register file write and readback
    add_step("mstrt_wr", aether_pkg::WR_REG, aether_pkg::MSTRT, 16'h12A5, 1'b0, '0);
    add_step("mstrt_rd", aether_pkg::RD_REG, aether_pkg::MSTRT, '0, 1'b1, 16'h12A5);
    add_step("mendd_wr", aether_pkg::WR_REG, aether_pkg::MENDD, 16'h3C4B, 1'b0, '0);
    add_step("mendd_rd", aether_pkg::RD_REG, aether_pkg::MENDD, '0, 1'b1, 16'h3C4B);
    add_step("bcfg1_wr", aether_pkg::WR_REG, aether_pkg::BCFG1, 16'h0003, 1'b0, '0);
    add_step("bcfg1_rd", aether_pkg::RD_REG, aether_pkg::BCFG1, '0, 1'b1, 16'h0003);
    add_step("bcfg1_wr_big", aether_pkg::WR_REG, aether_pkg::BCFG1, 16'h0007, 1'b0, '0);
    add_step("bcfg1_clamp", aether_pkg::RD_REG, aether_pkg::BCFG1, '0, 1'b1, 16'h0004);
    add_step("versn_wr", aether_pkg::WR_REG, aether_pkg::VERSN, 16'h1234, 1'b0, '0);
    add_step("versn_ro", aether_pkg::RD_REG, aether_pkg::VERSN, '0, 1'b1, 16'h6C00);
    // Fill the input buffer
    add_step("buf_start", aether_pkg::LDW_STRT, aether_pkg::VERSN, '0, 1'b0, '0);
    for (int k = 0; k < aether_pkg::WGT_DEPTH / 2; k++)
      add_step($sformatf("buf_word_%0d", k), aether_pkg::LDW_CONT, aether_pkg::VERSN,
               buf_words[k], 1'b0, '0);
    // Buffer into RAM at 16..33, then four engines of weights
    add_step("move_mstrt", aether_pkg::WR_REG, aether_pkg::MSTRT, 16'd16, 1'b0, '0);
    add_step("move_mendd", aether_pkg::WR_REG, aether_pkg::MENDD, 16'd33, 1'b0, '0);
    add_step("move", aether_pkg::LDW_MOVE, aether_pkg::VERSN, '0, 1'b0, '0);
    add_step("load_bcfg1", aether_pkg::WR_REG, aether_pkg::BCFG1, 16'd4, 1'b0, '0);
    add_step("load_full", aether_pkg::LDW_CWGT, aether_pkg::VERSN, '0, 1'b0, '0);
    add_weight_reads(aether_pkg::WGT_DEPTH);
  endtask

  // Two engines only, upper half of the store stays zero
  task automatic build_partial_steps();
    clear_steps();
    add_step("part_mstrt", aether_pkg::WR_REG, aether_pkg::MSTRT, 16'd16, 1'b0, '0);
    add_step("part_bcfg1", aether_pkg::WR_REG, aether_pkg::BCFG1, 16'd2, 1'b0, '0);
    add_step("part_bcfg1_rd", aether_pkg::RD_REG, aether_pkg::BCFG1, '0, 1'b1, 16'd2);
    add_step("load_part", aether_pkg::LDW_CWGT, aether_pkg::VERSN, '0, 1'b0, '0);
    add_weight_reads(2 * aether_pkg::KERNEL_TAPS);
  endtask

  // Low byte for even index, sign-extended
  function automatic aether_pkg::word_t expected_weight(input int idx);
    aether_pkg::weight_t b;
    if (idx % 2 == 1)
      b = buf_words[idx / 2][15:8];
    else
      b = buf_words[idx / 2][7:0];
    return {{8{b[7]}}, b};
  endfunction

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    arst_n_i = 1'b0;
    drive_idle();
    errors   = 0;
    timeouts = 0;
    seed     = 32'h108e_5256;
    for (int k = 0; k < aether_pkg::WGT_DEPTH / 2; k++)
      buf_words[k] = aether_pkg::word_t'($random(seed));
    for (int i = 0; i < aether_pkg::WGT_DEPTH; i++)
      wgt_model[i] = expected_weight(i);

    apply_reset();
    check_word("irq_reset", 16'h0000, {15'b0, interrupt_o});
    build_main_steps();
    run_steps();

    apply_reset();  // Store back to zero, RAM keeps its words
    check_word("irq_reset2", 16'h0000, {15'b0, interrupt_o});
    build_partial_steps();
    run_steps();

    $display("Summary: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: sources.f
design/aether_pkg.sv
design/aether_decoder.sv
design/aether_input_buffer.sv
design/aether_buffer_mover.sv
design/aether_weight_loader.sv
design/aether_mem_arbiter.sv
design/aether_sys_ram.sv
design/aether_engine.sv
verif/aether_clk_gen.sv
verif/aether_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass or fail from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module aether_engine_tb -o aether_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/aether_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
  exit 0
fi
exit 1
